// File: rtl/aluPkg.sv
// ALU shared types and constants
`default_nettype none

package aluPkg;

  // Default operand width, overridden only through the top level parameter.
  localparam int defaultDataWidth = 32;

  // Full-width data word as seen from outside the subsystem.
  typedef logic [31:0] aluWordT;

  // Command encoding. All eight codes are in use.
  typedef enum logic [2:0] {
    cmdAdd  = 3'd0,
    cmdSub  = 3'd1,
    cmdXor  = 3'd2,
    cmdSlt  = 3'd3,
    cmdAnd  = 3'd4,
    cmdNand = 3'd5,
    cmdNor  = 3'd6,
    cmdOr   = 3'd7
  } aluCmdT;

  // Unit that drives the core result.
  typedef enum logic [1:0] {
    selArith = 2'd0,
    selLogic = 2'd1,
    selSlt   = 2'd2
  } aluUnitSelT;

  // Base bitwise function before the optional inversion.
  typedef enum logic [1:0] {
    logicAnd = 2'd0,
    logicOr  = 2'd1,
    logicXor = 2'd2
  } logicOpT;

endpackage

`default_nettype wire

// File: rtl/aluAddSub.sv
// Ripple-carry adder and subtractor
`timescale 1ns/100ps
`default_nettype none

module aluAddSub
#(
  parameter int dataWidth = 32
)
(
  input  wire logic [dataWidth-1:0] a,
  input  wire logic [dataWidth-1:0] b,
  input  wire logic                 subtract,
  output logic      [dataWidth-1:0] sum,
  output logic                      carryOut,
  output logic                      overflow
);

  typedef logic [dataWidth-1:0] wordT;

  wordT               bInv;
  logic [dataWidth:0] carry;

  // Subtraction is A plus the ones complement of B plus one.
  assign bInv     = b ^ {dataWidth{subtract}};
  assign carry[0] = subtract;

  genvar i;
  generate
    for (i = 0; i < dataWidth; i++)
    begin : gBit
      logic halfSum;

      // One full-adder cell per bit.
      assign halfSum      = a[i] ^ bInv[i];
      assign sum[i]       = halfSum ^ carry[i];
      assign carry[i + 1] = (a[i] & bInv[i]) | (halfSum & carry[i]);
    end
  endgenerate

  assign carryOut = carry[dataWidth];

  // Signed overflow shows as a mismatch between the carries into and out of the sign bit.
  assign overflow = carry[dataWidth] ^ carry[dataWidth - 1];

endmodule

`default_nettype wire

// File: rtl/aluLogicUnit.sv
// ALU bitwise logic unit
`timescale 1ns/100ps
`default_nettype none

module aluLogicUnit import aluPkg::*;
#(
  parameter int dataWidth = defaultDataWidth
)
(
  input  wire logic [dataWidth-1:0] a,
  input  wire logic [dataWidth-1:0] b,
  input  wire logicOpT              logicOp,
  input  wire logic                 invert,
  output logic      [dataWidth-1:0] y
);

  typedef logic [dataWidth-1:0] wordT;

  wordT raw;

  always_comb
  begin
    case (logicOp)
      logicAnd: raw = a & b;
      logicOr:  raw = a | b;
      logicXor: raw = a ^ b;
      default:  raw = '0;
    endcase
  end

  // Inverting the AND and OR outputs gives NAND and NOR.
  assign y = raw ^ {dataWidth{invert}};

endmodule

`default_nettype wire

// File: rtl/aluCore.sv
// ALU combinational core
`timescale 1ns/100ps
`default_nettype none

module aluCore import aluPkg::*;
#(
  parameter int dataWidth = defaultDataWidth
)
(
  input  wire logic [dataWidth-1:0] regA,
  input  wire logic [dataWidth-1:0] regB,
  input  wire logic                 subtract,
  input  wire logic                 invert,
  input  wire logicOpT              logicOp,
  input  wire aluUnitSelT           unitSel,
  output logic      [dataWidth-1:0] coreResult,
  output logic                      coreCarry,
  output logic                      coreOverflow
);

  typedef logic [dataWidth-1:0] wordT;

  wordT sum;
  wordT logicY;
  wordT sltWord;

  aluAddSub #(
    .dataWidth (dataWidth)
  ) uAddSub (
    .a        (regA),
    .b        (regB),
    .subtract (subtract),
    .sum      (sum),
    .carryOut (coreCarry),
    .overflow (coreOverflow)
  );

  aluLogicUnit #(
    .dataWidth (dataWidth)
  ) uLogic (
    .a       (regA),
    .b       (regB),
    .logicOp (logicOp),
    .invert  (invert),
    .y       (logicY)
  );

  // A is less than B when the sign of A minus B disagrees with the overflow.
  assign sltWord = {{(dataWidth - 1){1'b0}}, sum[dataWidth - 1] ^ coreOverflow};

  always_comb
  begin
    case (unitSel)
      selArith: coreResult = sum;
      selLogic: coreResult = logicY;
      selSlt:   coreResult = sltWord;
      default:  coreResult = '0;
    endcase
  end

  // The operand stage decode only ever produces the three defined unit codes.
  always_comb
  begin
    unitSelLegal: assert final (unitSel !== 2'b11)
      else $error("aluCore: unitSel holds the unused encoding");
  end

endmodule

`default_nettype wire

// File: rtl/aluOperandStage.sv
// ALU operand capture and command decode
`timescale 1ns/100ps
`default_nettype none

module aluOperandStage import aluPkg::*;
#(
  parameter int dataWidth = defaultDataWidth
)
(
  input  wire logic                 clk,
  input  wire logic                 arstN,
  input  wire logic                 inStrobe,
  input  wire logic [dataWidth-1:0] operandA,
  input  wire logic [dataWidth-1:0] operandB,
  input  wire aluCmdT               cmd,
  output logic      [dataWidth-1:0] regA,
  output logic      [dataWidth-1:0] regB,
  output logic                      subtract,
  output logic                      invert,
  output logicOpT                   logicOp,
  output aluUnitSelT                unitSel,
  output logic                      flagEnable,
  output logic                      stageValid
);

  logic       subtractNext;
  logic       invertNext;
  logic       flagEnableNext;
  logicOpT    logicOpNext;
  aluUnitSelT unitSelNext;

  // Map each command onto the control levels used by the core.
  always_comb
  begin
    subtractNext   = 1'b0;
    invertNext     = 1'b0;
    flagEnableNext = 1'b0;
    logicOpNext    = logicAnd;
    unitSelNext    = selLogic;
    case (cmd)
      cmdAdd:
      begin
        unitSelNext    = selArith;
        flagEnableNext = 1'b1;
      end
      cmdSub:
      begin
        unitSelNext    = selArith;
        subtractNext   = 1'b1;
        flagEnableNext = 1'b1;
      end
      cmdSlt:
      begin
        // SLT reuses the subtractor and never reports flags.
        unitSelNext  = selSlt;
        subtractNext = 1'b1;
      end
      cmdXor:  logicOpNext = logicXor;
      cmdAnd:  logicOpNext = logicAnd;
      cmdNand:
      begin
        logicOpNext = logicAnd;
        invertNext  = 1'b1;
      end
      cmdNor:
      begin
        logicOpNext = logicOr;
        invertNext  = 1'b1;
      end
      cmdOr:   logicOpNext = logicOr;
      default: logicOpNext = logicAnd;
    endcase
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      stageValid <= 1'b0;
      subtract   <= 1'b0;
      invert     <= 1'b0;
      flagEnable <= 1'b0;
      logicOp    <= logicAnd;
      unitSel    <= selArith;
    end
    else
    begin
      stageValid <= inStrobe;
      if (inStrobe)
      begin
        subtract   <= subtractNext;
        invert     <= invertNext;
        flagEnable <= flagEnableNext;
        logicOp    <= logicOpNext;
        unitSel    <= unitSelNext;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (inStrobe)
    begin
      regA <= operandA;
      regB <= operandB;
    end
  end

  // A strobed command must be fully defined.
  cmdKnownOnStrobe: assert property (@(posedge clk) disable iff (!arstN)
    inStrobe |-> !$isunknown(cmd))
    else $error("aluOperandStage: command has unknown bits on a strobe");

endmodule

`default_nettype wire

// File: rtl/aluResultStage.sv
// ALU result and flag registers
`timescale 1ns/100ps
`default_nettype none

module aluResultStage
#(
  parameter int dataWidth = 32
)
(
  input  wire logic                 clk,
  input  wire logic                 arstN,
  input  wire logic                 stageValid,
  input  wire logic                 flagEnable,
  input  wire logic [dataWidth-1:0] coreResult,
  input  wire logic                 coreCarry,
  input  wire logic                 coreOverflow,
  output logic                      outValid,
  output logic      [dataWidth-1:0] result,
  output logic                      carryOut,
  output logic                      overflow,
  output logic                      zero
);

  logic zeroRaw;

  assign zeroRaw = ~|coreResult;

  // Flags only carry meaning for ADD and SUB, so they are cleared otherwise.
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      outValid <= 1'b0;
      result   <= '0;
      carryOut <= 1'b0;
      overflow <= 1'b0;
      zero     <= 1'b0;
    end
    else
    begin
      outValid <= stageValid;
      if (stageValid)
      begin
        result   <= coreResult;
        carryOut <= coreCarry & flagEnable;
        overflow <= coreOverflow & flagEnable;
        zero     <= zeroRaw & flagEnable;
      end
    end
  end

  // Every item taken into the output registers must be fully defined.
  itemKnown: assert property (@(posedge clk) disable iff (!arstN)
    stageValid |-> !$isunknown({flagEnable, coreCarry, coreOverflow, coreResult}))
    else $error("aluResultStage: item with unknown bits reached the output registers");

endmodule

`default_nettype wire

// File: rtl/aluTop.sv
// Registered ALU subsystem top
`timescale 1ns/100ps
`default_nettype none

module aluTop import aluPkg::*;
#(
  parameter int dataWidth = defaultDataWidth
)
(
  input  wire logic                 clk,
  input  wire logic                 arstN,
  input  wire logic                 inStrobe,
  input  wire logic [dataWidth-1:0] operandA,
  input  wire logic [dataWidth-1:0] operandB,
  input  wire aluCmdT               cmd,
  output logic                      outValid,
  output logic      [dataWidth-1:0] result,
  output logic                      carryOut,
  output logic                      overflow,
  output logic                      zero
);

  typedef logic [dataWidth-1:0] wordT;

  wordT       regA;
  wordT       regB;
  wordT       coreResult;
  logic       subtract;
  logic       invert;
  logicOpT    logicOp;
  aluUnitSelT unitSel;
  logic       flagEnable;
  logic       stageValid;
  logic       coreCarry;
  logic       coreOverflow;

  aluOperandStage #(
    .dataWidth (dataWidth)
  ) uOperand (
    .clk        (clk),
    .arstN      (arstN),
    .inStrobe   (inStrobe),
    .operandA   (operandA),
    .operandB   (operandB),
    .cmd        (cmd),
    .regA       (regA),
    .regB       (regB),
    .subtract   (subtract),
    .invert     (invert),
    .logicOp    (logicOp),
    .unitSel    (unitSel),
    .flagEnable (flagEnable),
    .stageValid (stageValid)
  );

  aluCore #(
    .dataWidth (dataWidth)
  ) uCore (
    .regA         (regA),
    .regB         (regB),
    .subtract     (subtract),
    .invert       (invert),
    .logicOp      (logicOp),
    .unitSel      (unitSel),
    .coreResult   (coreResult),
    .coreCarry    (coreCarry),
    .coreOverflow (coreOverflow)
  );

  // The core is combinational, so valid and flag enable go straight to the output stage.
  aluResultStage #(
    .dataWidth (dataWidth)
  ) uResult (
    .clk          (clk),
    .arstN        (arstN),
    .stageValid   (stageValid),
    .flagEnable   (flagEnable),
    .coreResult   (coreResult),
    .coreCarry    (coreCarry),
    .coreOverflow (coreOverflow),
    .outValid     (outValid),
    .result       (result),
    .carryOut     (carryOut),
    .overflow     (overflow),
    .zero         (zero)
  );

endmodule

`default_nettype wire

// File: verification/aluChecker.sv
// ALU output checker
`timescale 1ns/100ps
`default_nettype none

module aluChecker import aluPkg::*;
(
  input  wire logic    clk,
  input  wire logic    arstN,
  input  wire logic    inStrobe,
  input  wire aluWordT operandA,
  input  wire aluWordT operandB,
  input  wire aluCmdT  cmd,
  input  wire logic    outValid,
  input  wire aluWordT result,
  input  wire logic    carryOut,
  input  wire logic    overflow,
  input  wire logic    zero,
  output int           mismatchCount,
  output int           protocolCount,
  output int           checkedCount
);

  // Each expected item is packed as result, carry, overflow and zero.
  logic [34:0] expQ[$];
  int          stampQ[$];
  int          cycle;

  // Reference model of the operation library.
  function automatic logic [34:0] refAlu(input aluCmdT c, input aluWordT a, input aluWordT b);
    logic [32:0] wide;
    aluWordT     r;
    logic        cy;
    logic        ov;
    cy = 1'b0;
    ov = 1'b0;
    case (c)
      cmdAdd:
      begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[31:0];
        cy = wide[32];
        ov = (a[31] == b[31]) && (r[31] != a[31]);
      end
      cmdSub:
      begin
        // A carry out of a subtraction means that no borrow occurred.
        r = a - b;
        cy = (a >= b);
        ov = (a[31] != b[31]) && (r[31] != a[31]);
      end
      cmdSlt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cmdXor:  r = a ^ b;
      cmdAnd:  r = a & b;
      cmdNand: r = ~(a & b);
      cmdOr:   r = a | b;
      cmdNor:  r = ~(a | b);
      default: r = '0;
    endcase
    return {r, cy, ov, ((c == cmdAdd) || (c == cmdSub)) && (r == '0)};
  endfunction

  task automatic checkField(input string name, input aluWordT expected, input aluWordT actual);
    if (expected !== actual)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  // Called once the stimulus has stopped and the pipeline has had time to empty.
  task automatic checkDrained();
    if (expQ.size() != 0)
    begin
      $display("Checker: %0d strobed items never came out of the DUT", expQ.size());
      protocolCount += expQ.size();
    end
  endtask

  initial
  begin
    mismatchCount = 0;
    protocolCount = 0;
    checkedCount  = 0;
    cycle         = 0;
  end

  always @(posedge clk)
  begin
    logic [34:0] exp;
    int          stamp;
    cycle++;
    if (arstN)
    begin
      if (outValid)
      begin
        if (expQ.size() == 0)
        begin
          $display("Checker: outValid at %0t with no item in flight", $time);
          protocolCount++;
        end
        else
        begin
          exp = expQ.pop_front();
          stamp = stampQ.pop_front();
          if (cycle - stamp != 2)
          begin
            $display("Checker: item strobed in cycle %0d came out in cycle %0d, not 2 edges later",
                     stamp, cycle);
            protocolCount++;
          end
          checkField("result", exp[34:3], result);
          checkField("carryOut", exp[2], carryOut);
          checkField("overflow", exp[1], overflow);
          checkField("zero", exp[0], zero);
          checkedCount++;
        end
      end
      else if (checkedCount == 0)
      begin
        // Until the first item leaves, the outputs still hold their reset values.
        checkField("result", '0, result);
        checkField("carryOut", '0, carryOut);
        checkField("overflow", '0, overflow);
        checkField("zero", '0, zero);
      end
      if (inStrobe)
      begin
        expQ.push_back(refAlu(cmd, operandA, operandB));
        stampQ.push_back(cycle);
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/aluTb.sv
// ALU subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module aluTb import aluPkg::*;
();

  localparam int testCycles = 300;
  // Leaves a wide margin over the stimulus and the reset.
  localparam int cycleLimit = 6 * testCycles + 200;

  logic    clk;
  logic    arstN;
  logic    inStrobe;
  aluWordT operandA;
  aluWordT operandB;
  aluCmdT  cmd;
  logic    outValid;
  aluWordT result;
  logic    carryOut;
  logic    overflow;
  logic    zero;
  int      mismatchCount;
  int      protocolCount;
  int      checkedCount;
  int      cycleCount;
  logic [31:0] rngState;

  aluTop #(
    .dataWidth (32)
  ) DUT (
    .clk      (clk),
    .arstN    (arstN),
    .inStrobe (inStrobe),
    .operandA (operandA),
    .operandB (operandB),
    .cmd      (cmd),
    .outValid (outValid),
    .result   (result),
    .carryOut (carryOut),
    .overflow (overflow),
    .zero     (zero)
  );

  aluChecker uChecker (
    .clk           (clk),
    .arstN         (arstN),
    .inStrobe      (inStrobe),
    .operandA      (operandA),
    .operandB      (operandB),
    .cmd           (cmd),
    .outValid      (outValid),
    .result        (result),
    .carryOut      (carryOut),
    .overflow      (overflow),
    .zero          (zero),
    .mismatchCount (mismatchCount),
    .protocolCount (protocolCount),
    .checkedCount  (checkedCount)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic applyOp(input aluCmdT c, input aluWordT a, input aluWordT b);
    @(negedge clk);
    inStrobe = 1'b1;
    cmd      = c;
    operandA = a;
    operandB = b;
  endtask

  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      inStrobe = 1'b0;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    aluWordT a;
    aluWordT b;
    aluCmdT  randCmd;
    arstN    = 1'b0;
    inStrobe = 1'b0;
    cmd      = cmdAdd;
    operandA = '0;
    operandB = '0;
    rngState = 32'h2bd5;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    // Nothing may come out while the input stays idle.
    idleCycles(4);
    applyOp(cmdAdd, 32'h7fffffff, 32'h00000001);
    applyOp(cmdAdd, 32'hffffffff, 32'h00000001);
    applyOp(cmdAdd, 32'h80000000, 32'h80000000);
    applyOp(cmdAdd, 32'h12345678, 32'h0edcba98);
    applyOp(cmdSub, 32'h00000000, 32'h00000001);
    applyOp(cmdSub, 32'hdeadbeef, 32'hdeadbeef);
    applyOp(cmdSub, 32'h80000000, 32'h00000001);
    applyOp(cmdSub, 32'h00000005, 32'h00000003);
    idleCycles(2);
    // Signed compares, several of which overflow inside the subtractor.
    applyOp(cmdSlt, 32'h80000000, 32'h00000001);
    applyOp(cmdSlt, 32'h00000001, 32'h80000000);
    applyOp(cmdSlt, 32'h7fffffff, 32'h80000000);
    applyOp(cmdSlt, 32'h80000000, 32'h7fffffff);
    applyOp(cmdSlt, 32'hffffffff, 32'h00000000);
    applyOp(cmdSlt, 32'h00000005, 32'h00000005);
    // Bitwise results of zero must still leave every flag low.
    applyOp(cmdAnd, 32'hf0f0f0f0, 32'h0f0f0f0f);
    applyOp(cmdXor, 32'h3c3c3c3c, 32'h3c3c3c3c);
    applyOp(cmdNor, 32'hffffffff, 32'h00000000);
    applyOp(cmdNand, 32'hffffffff, 32'hffffffff);
    applyOp(cmdOr, 32'h00000000, 32'h00000000);
    idleCycles(3);
    for (int i = 0; i < 8; i++)
    begin
      rngState = xorshift32(rngState);
      a = rngState;
      rngState = xorshift32(rngState);
      applyOp(aluCmdT'(i[2:0]), a, rngState);
    end
    for (int n = 0; n < 250; n++)
    begin
      rngState = xorshift32(rngState);
      if (rngState[2:0] == 3'd0)
      begin
        idleCycles(1);
      end
      else
      begin
        randCmd = aluCmdT'(rngState[10:8]);
        // Equal operands now and then to reach a zero result.
        if (rngState[15:13] == 3'd0)
        begin
          rngState = xorshift32(rngState);
          a = rngState;
          b = a;
        end
        else
        begin
          rngState = xorshift32(rngState);
          a = rngState;
          rngState = xorshift32(rngState);
          b = rngState;
        end
        applyOp(randCmd, a, b);
      end
    end
    idleCycles(4);
    uChecker.checkDrained();
    $display("Checked %0d items: %0d value errors, %0d protocol errors",
             checkedCount, mismatchCount, protocolCount);
    if (mismatchCount + protocolCount == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/aluPkg.sv
rtl/aluAddSub.sv
rtl/aluLogicUnit.sv
rtl/aluCore.sv
rtl/aluOperandStage.sv
rtl/aluResultStage.sv
rtl/aluTop.sv
verification/aluChecker.sv
verification/aluTb.sv
